// ==== build.f ====
+incdir+logic
logic/circle_pkg.sv
logic/pixel_if.sv
logic/circle_regs.sv
logic/circle_engine.sv
logic/pixel_queue.sv
logic/circle_top.sv
sim/circle_checker.sv
sim/circle_tb.sv

// ==== logic/circle_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "circle_settings.svh"

module circle_engine (
    input  wire                            vif,
    input  wire                            rst_n,
    input  wire                            go,
    input  wire [`X_BITS-1:0]              job_centre_x,
    input  wire [`Y_BITS-1:0]              job_centre_y,
    input  wire [`RADIUS_BITS-1:0]         job_radius,
    input  wire [`COLOUR_BITS-1:0]         job_colour,
    pixel_if.src                           px,
    output circle_pkg::draw_state_t        state,
    output logic                           finished
);

    localparam int x_w = `X_BITS;
    localparam int y_w = `Y_BITS;
    // signed candidate width holds centre plus offset up to 255 + 255
    localparam int cand_w = ((`X_BITS > `RADIUS_BITS) ? `X_BITS : `RADIUS_BITS) + 2;
    localparam int cnt_w = $clog2(`CREDITS + 1);

    // credits not yet spent on a pixel
    logic [cnt_w-1:0] credits;
    logic issue;

    // clear sweep position
    logic [x_w-1:0] clr_x;
    logic [y_w-1:0] clr_y;
    logic clr_row_end;
    logic clr_last;

    // midpoint state is signed so that offset_x may drop below zero
    logic signed [cand_w-1:0] offset_x;
    logic signed [cand_w-1:0] offset_y;
    logic signed [cand_w:0] crit;
    logic signed [cand_w-1:0] centre_sx;
    logic signed [cand_w-1:0] centre_sy;
    logic signed [cand_w-1:0] radius_s;
    logic step_more;
    logic advance;
    logic signed [cand_w-1:0] next_ox;
    logic signed [cand_w-1:0] next_oy;
    logic signed [cand_w-1:0] next_diff;
    logic signed [cand_w:0] next_crit;

    // eight octant candidates of the current step
    logic signed [cand_w-1:0] cand_x [8];
    logic signed [cand_w-1:0] cand_y [8];
    logic [7:0] on_screen;
    logic [7:0] pending;
    logic [7:0] pending_left;
    logic [2:0] pick_idx;
    circle_pkg::pixel_t next_pixel;

    assign centre_sx = $signed({{(cand_w - `X_BITS){1'b0}}, job_centre_x});
    assign centre_sy = $signed({{(cand_w - `Y_BITS){1'b0}}, job_centre_y});
    assign radius_s  = $signed({{(cand_w - `RADIUS_BITS){1'b0}}, job_radius});

    assign clr_row_end = (clr_x == x_w'(`SCREEN_W - 1));
    assign clr_last    = clr_row_end && (clr_y == y_w'(`SCREEN_H - 1));

    // loop runs while offset_y <= offset_x
    assign step_more = (offset_y <= offset_x);

    // octant points then clipping against the screen
    always_comb begin
        cand_x[0] = centre_sx + offset_x;
        cand_y[0] = centre_sy + offset_y;
        cand_x[1] = centre_sx + offset_y;
        cand_y[1] = centre_sy + offset_x;
        cand_x[2] = centre_sx - offset_y;
        cand_y[2] = centre_sy + offset_x;
        cand_x[3] = centre_sx - offset_x;
        cand_y[3] = centre_sy + offset_y;
        cand_x[4] = centre_sx - offset_x;
        cand_y[4] = centre_sy - offset_y;
        cand_x[5] = centre_sx - offset_y;
        cand_y[5] = centre_sy - offset_x;
        cand_x[6] = centre_sx + offset_y;
        cand_y[6] = centre_sy - offset_x;
        cand_x[7] = centre_sx + offset_x;
        cand_y[7] = centre_sy - offset_y;
        for (int i = 0; i < 8; i++) begin
            on_screen[i] = (cand_x[i] >= 0) && (cand_x[i] < `SCREEN_W) &&
                           (cand_y[i] >= 0) && (cand_y[i] < `SCREEN_H);
        end
    end

    // lowest pending octant goes next
    always_comb begin
        pick_idx = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx = 3'(i);
            end
        end
        pending_left = pending & ~(8'd1 << pick_idx);
    end

    // next midpoint step
    always_comb begin
        next_oy = offset_y + 1'b1;
        if (crit <= 0) begin
            next_ox   = offset_x;
            next_diff = next_oy;
        end else begin
            next_ox   = offset_x - 1'b1;
            next_diff = next_oy - next_ox;
        end
        // crit + 2*diff + 1
        next_crit = crit + $signed({next_diff, 1'b1});
    end

    // pixel to issue this cycle when a credit is in hand
    always_comb begin
        issue      = 1'b0;
        next_pixel = '0;
        case (state)
            circle_pkg::clear: begin
                issue             = (credits != '0);
                next_pixel.x      = clr_x;
                next_pixel.y      = clr_y;
                next_pixel.colour = '0;
            end
            circle_pkg::plot_octants: begin
                issue             = (credits != '0);
                next_pixel.x      = cand_x[pick_idx][x_w-1:0];
                next_pixel.y      = cand_y[pick_idx][y_w-1:0];
                next_pixel.colour = job_colour;
            end
            default: begin
                issue = 1'b0;
            end
        endcase
    end

    // step ends when all points are off screen or the last octant just went out
    assign advance = ((state == circle_pkg::walk) && step_more && (on_screen == '0)) ||
                     ((state == circle_pkg::plot_octants) && issue && (pending_left == '0));

    always_ff @(posedge vif) begin
        if (!rst_n) begin
            state    <= circle_pkg::idle;
            finished <= 1'b0;
            credits  <= cnt_w'(`CREDITS);
            px.valid <= 1'b0;
        end else begin
            finished <= 1'b0;
            // spend one on issue and get back what the queue sent out
            credits  <= credits - cnt_w'(issue) + cnt_w'(px.credit);
            px.valid <= issue;
            case (state)
                circle_pkg::idle: begin
                    if (go) begin
                        state <= circle_pkg::clear;
                    end
                end
                circle_pkg::clear: begin
                    if (issue && clr_last) begin
                        state <= circle_pkg::walk;
                    end
                end
                circle_pkg::walk: begin
                    if (!step_more) begin
                        state <= circle_pkg::drain;
                    end else if (on_screen != '0) begin
                        state <= circle_pkg::plot_octants;
                    end
                end
                circle_pkg::plot_octants: begin
                    if (advance) begin
                        state <= circle_pkg::walk;
                    end
                end
                circle_pkg::drain: begin
                    // last pixel written and gone from the queue
                    if (px.empty) begin
                        state    <= circle_pkg::idle;
                        finished <= 1'b1;
                    end
                end
                default: begin
                    state <= circle_pkg::idle;
                end
            endcase
        end
    end

    // sweep counters, midpoint registers and outgoing pixel
    always_ff @(posedge vif) begin
        if (issue) begin
            px.pixel <= next_pixel;
        end
        if ((state == circle_pkg::idle) && go) begin
            clr_x    <= '0;
            clr_y    <= '0;
            offset_x <= radius_s;
            offset_y <= '0;
            // 1 - radius
            crit     <= {{cand_w{1'b0}}, 1'b1} - {radius_s[cand_w-1], radius_s};
        end
        if ((state == circle_pkg::clear) && issue) begin
            if (clr_row_end) begin
                clr_x <= '0;
                clr_y <= clr_y + 1'b1;
            end else begin
                clr_x <= clr_x + 1'b1;
            end
        end
        if ((state == circle_pkg::walk) && step_more) begin
            pending <= on_screen;
        end
        if ((state == circle_pkg::plot_octants) && issue) begin
            pending <= pending_left;
        end
        if (advance) begin
            offset_x <= next_ox;
            offset_y <= next_oy;
            crit     <= next_crit;
        end
    end

endmodule

`default_nettype wire

// ==== logic/circle_pkg.sv ====
`default_nettype none

`include "circle_settings.svh"

package circle_pkg;

    // one framebuffer write
    // x in the top bits, colour in the bottom bits
    typedef struct packed {
        logic [`X_BITS-1:0]      x;
        logic [`Y_BITS-1:0]      y;
        logic [`COLOUR_BITS-1:0] colour;
    } pixel_t;

    // drawing engine FSM
    // idle         waiting for go
    // clear        sweeping the screen with colour 0
    // walk         one midpoint step, decides the octant set
    // plot_octants issuing the in-screen points of the step
    // drain        waiting for the output queue to empty
    typedef enum logic [2:0] {
        idle,
        clear,
        walk,
        plot_octants,
        drain
    } draw_state_t;

endpackage

`default_nettype wire

// ==== logic/circle_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "circle_settings.svh"

module circle_regs (
    input  wire                          vif,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire [`X_BITS-1:0]            centre_x,
    input  wire [`Y_BITS-1:0]            centre_y,
    input  wire [`RADIUS_BITS-1:0]       radius,
    input  wire [`COLOUR_BITS-1:0]       colour,
    input  wire circle_pkg::draw_state_t engine_state,
    input  wire                          finished,
    output logic                         go,
    output logic [`X_BITS-1:0]           job_centre_x,
    output logic [`Y_BITS-1:0]           job_centre_y,
    output logic [`RADIUS_BITS-1:0]      job_radius,
    output logic [`COLOUR_BITS-1:0]      job_colour,
    output logic                         done
);

    // job accepted, waiting for the engine to finish
    logic job_active;
    // engine still working on something
    logic engine_busy;
    // start seen with nothing in progress
    logic accept;

    assign engine_busy = (engine_state != circle_pkg::idle);

    // done must have been cleared by start going low first
    assign accept = start && !job_active && !done && !engine_busy;

    // start/done handshake
    always_ff @(posedge vif) begin
        if (!rst_n) begin
            go         <= 1'b0;
            job_active <= 1'b0;
            done       <= 1'b0;
        end else begin
            // single cycle go toward the engine
            go <= accept;

            if (accept) begin
                job_active <= 1'b1;
            end else if (finished) begin
                job_active <= 1'b0;
            end

            // done rises one cycle after finished and holds until start drops
            if (finished) begin
                done <= 1'b1;
            end else if (!start) begin
                done <= 1'b0;
            end
        end
    end

    // job fields frozen for the whole draw
    always_ff @(posedge vif) begin
        if (accept) begin
            job_centre_x <= centre_x;
            job_centre_y <= centre_y;
            job_radius   <= radius;
            job_colour   <= colour;
        end
    end

endmodule

`default_nettype wire

// ==== logic/circle_settings.svh ====
`ifndef CIRCLE_SETTINGS_SVH
`define CIRCLE_SETTINGS_SVH

// visible screen in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// coordinate widths, enough for 0..159 and 0..119
`define X_BITS 8
`define Y_BITS 7

// 3-bit colour, 0 is the clear colour
`define COLOUR_BITS 3

// radius up to 255
`define RADIUS_BITS 8

// output queue depth and engine starting credits, 2 or more
`define CREDITS 4

`endif

// ==== logic/circle_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "circle_settings.svh"

module circle_top (
    input  wire                      vif,
    input  wire                      rst_n,
    input  wire                      start,
    input  wire [`X_BITS-1:0]        centre_x,
    input  wire [`Y_BITS-1:0]        centre_y,
    input  wire [`RADIUS_BITS-1:0]   radius,
    input  wire [`COLOUR_BITS-1:0]   colour,
    output logic                     done,
    output logic [`X_BITS-1:0]       vga_x,
    output logic [`Y_BITS-1:0]       vga_y,
    output logic [`COLOUR_BITS-1:0]  vga_colour,
    output logic                     vga_plot,
    input  wire                      vga_ready
);

    // job from the register block
    logic                      go;
    logic [`X_BITS-1:0]        job_centre_x;
    logic [`Y_BITS-1:0]        job_centre_y;
    logic [`RADIUS_BITS-1:0]   job_radius;
    logic [`COLOUR_BITS-1:0]   job_colour;

    // engine status back
    circle_pkg::draw_state_t   engine_state;
    logic                      finished;

    // engine to queue, pixels one way and credits back
    pixel_if px_link ();

    circle_regs i_circle_regs (
        .vif          (vif),
        .rst_n        (rst_n),
        .start        (start),
        .centre_x     (centre_x),
        .centre_y     (centre_y),
        .radius       (radius),
        .colour       (colour),
        .engine_state (engine_state),
        .finished     (finished),
        .go           (go),
        .job_centre_x (job_centre_x),
        .job_centre_y (job_centre_y),
        .job_radius   (job_radius),
        .job_colour   (job_colour),
        .done         (done)
    );

    circle_engine i_circle_engine (
        .vif          (vif),
        .rst_n        (rst_n),
        .go           (go),
        .job_centre_x (job_centre_x),
        .job_centre_y (job_centre_y),
        .job_radius   (job_radius),
        .job_colour   (job_colour),
        .px           (px_link.src),
        .state        (engine_state),
        .finished     (finished)
    );

    pixel_queue i_pixel_queue (
        .vif        (vif),
        .rst_n      (rst_n),
        .px         (px_link.sink),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot),
        .vga_ready  (vga_ready)
    );

endmodule

`default_nettype wire

// ==== logic/pixel_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface pixel_if;

    // engine side, a pixel is taken on every clock with valid high
    logic               valid;
    circle_pkg::pixel_t pixel;

    // queue side
    // credit pulses once per pixel sent to the vga port
    logic               credit;
    logic               empty;

    // drawing engine
    modport src (
        output valid,
        output pixel,
        input  credit,
        input  empty
    );

    // output queue
    modport sink (
        input  valid,
        input  pixel,
        output credit,
        output empty
    );

endinterface

`default_nettype wire

// ==== logic/pixel_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "circle_settings.svh"

module pixel_queue (
    input  wire                      vif,
    input  wire                      rst_n,
    pixel_if.sink                    px,
    output logic [`X_BITS-1:0]       vga_x,
    output logic [`Y_BITS-1:0]       vga_y,
    output logic [`COLOUR_BITS-1:0]  vga_colour,
    output logic                     vga_plot,
    input  wire                      vga_ready
);

    localparam int depth = `CREDITS;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    circle_pkg::pixel_t mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    // head accepted by the vga adapter
    logic pop;

    assign px.empty  = (count == '0);
    assign pop       = !px.empty && vga_ready;
    // one credit back per pixel gone
    assign px.credit = pop;

    // head of the queue straight onto the write port
    assign vga_plot   = !px.empty;
    assign vga_x      = mem[rd_ptr].x;
    assign vga_y      = mem[rd_ptr].y;
    assign vga_colour = mem[rd_ptr].colour;

    // pointers wrap at depth, not always a power of two
    always_ff @(posedge vif) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (px.valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(px.valid) - cnt_w'(pop);
        end
    end

    // engine never writes without a credit so no full check
    always_ff @(posedge vif) begin
        if (px.valid) begin
            mem[wr_ptr] <= px.pixel;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the circle testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing -Wno-fatal --top-module circle_tb \
    -f build.f --Mdir obj_dir -o circle_sim > "$log" 2>&1 &&
    ./obj_dir/circle_sim >> "$log" 2>&1 ||
    { cat "$log"; echo "build or simulation did not complete"; exit 1; }

cat "$log"
grep -q "CHECKS FAILED" "$log" && { echo "simulation reported failure"; exit 1; } ||
    { echo "simulation clean"; exit 0; }

// ==== sim/circle_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "circle_settings.svh"

module circle_checker (
    input  wire                     vif,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire [`X_BITS-1:0]       centre_x,
    input  wire [`Y_BITS-1:0]       centre_y,
    input  wire [`RADIUS_BITS-1:0]  radius,
    input  wire [`COLOUR_BITS-1:0]  colour,
    input  wire                     done,
    input  wire [`X_BITS-1:0]       vga_x,
    input  wire [`Y_BITS-1:0]       vga_y,
    input  wire [`COLOUR_BITS-1:0]  vga_colour,
    input  wire                     vga_plot,
    input  wire                     vga_ready,
    output int                      errors,
    output int                      jobs_seen,
    output int                      total_writes
);

    localparam int screen_px = `SCREEN_W * `SCREEN_H;

    // framebuffer as written through the vga port, and the model of it
    logic [`COLOUR_BITS-1:0] frame [`SCREEN_W][`SCREEN_H];
    logic [`COLOUR_BITS-1:0] expect_frame [`SCREEN_W][`SCREEN_H];
    // pixels hit during the clear sweep
    bit cleared [`SCREEN_W][`SCREEN_H];

    int error_total = 0;
    int job_total = 0;
    int write_total = 0;

    // job as the design should have captured it
    bit in_job;
    bit armed;
    bit done_prev;
    bit start_was_low;
    int job_no;
    int job_cx;
    int job_cy;
    int job_r;
    logic [`COLOUR_BITS-1:0] job_col;
    int job_writes;
    int expect_visits;

    assign errors       = error_total;
    assign jobs_seen    = job_total;
    assign total_writes = write_total;

    task automatic report_mismatch(input string name, input string expected,
                                   input string actual);
        error_total++;
        $display("CHECK FAILED %s expected %s actual %s", name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        error_total++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // one midpoint candidate, clipped to the screen
    task automatic visit(input int x, input int y);
        if (x >= 0 && x < `SCREEN_W && y >= 0 && y < `SCREEN_H) begin
            expect_visits++;
            expect_frame[x][y] = job_col;
        end
    endtask

    // expected screen after the job: all zero plus the circle outline
    task automatic build_expected();
        int ox;
        int oy;
        int crit;
        expect_visits = 0;
        for (int x = 0; x < `SCREEN_W; x++) begin
            for (int y = 0; y < `SCREEN_H; y++) begin
                expect_frame[x][y] = '0;
                cleared[x][y] = 1'b0;
            end
        end
        ox = job_r;
        oy = 0;
        crit = 1 - job_r;
        while (oy <= ox) begin
            visit(job_cx + ox, job_cy + oy);
            visit(job_cx + oy, job_cy + ox);
            visit(job_cx - oy, job_cy + ox);
            visit(job_cx - ox, job_cy + oy);
            visit(job_cx - ox, job_cy - oy);
            visit(job_cx - oy, job_cy - ox);
            visit(job_cx + oy, job_cy - ox);
            visit(job_cx + ox, job_cy - oy);
            oy++;
            if (crit <= 0) begin
                crit = crit + 2 * oy + 1;
            end else begin
                ox--;
                crit = crit + 2 * (oy - ox) + 1;
            end
        end
    endtask

    // one accepted write on the vga port
    task automatic take_write();
        circle_pkg::pixel_t wr;
        wr.x = vga_x;
        wr.y = vga_y;
        wr.colour = vga_colour;
        write_total++;
        if (!in_job) begin
            report_problem($sformatf("write to %0d,%0d with no job in progress", wr.x, wr.y));
        end
        if (wr.x >= `SCREEN_W || wr.y >= `SCREEN_H) begin
            report_mismatch($sformatf("job %0d write on screen", job_no),
                            $sformatf("x<%0d y<%0d", `SCREEN_W, `SCREEN_H),
                            $sformatf("x=%0d y=%0d", wr.x, wr.y));
        end else begin
            // first screen_px writes are the clear sweep
            if (job_writes < screen_px) begin
                if (wr.colour != '0) begin
                    report_mismatch($sformatf("job %0d clear colour", job_no), "0",
                                    $sformatf("%0d", wr.colour));
                end
                if (cleared[wr.x][wr.y]) begin
                    report_problem($sformatf("clear wrote %0d,%0d twice", wr.x, wr.y));
                end
                cleared[wr.x][wr.y] = 1'b1;
            end
            frame[wr.x][wr.y] = wr.colour;
        end
        job_writes++;
    endtask

    // end of job, framebuffer and write count against the model
    task automatic finish_job();
        int bad;
        int covered;
        bad = 0;
        covered = 0;
        job_total++;
        if (job_writes != screen_px + expect_visits) begin
            report_mismatch($sformatf("job %0d write count", job_no),
                            $sformatf("%0d", screen_px + expect_visits),
                            $sformatf("%0d", job_writes));
        end
        for (int x = 0; x < `SCREEN_W; x++) begin
            for (int y = 0; y < `SCREEN_H; y++) begin
                if (cleared[x][y]) begin
                    covered++;
                end
                if (frame[x][y] !== expect_frame[x][y]) begin
                    // only the first bad pixel is spelled out
                    if (bad == 0) begin
                        report_mismatch($sformatf("job %0d pixel %0d,%0d", job_no, x, y),
                                        $sformatf("%0d", expect_frame[x][y]),
                                        $sformatf("%0d", frame[x][y]));
                    end
                    bad++;
                end
            end
        end
        if (bad > 1) begin
            report_mismatch($sformatf("job %0d wrong pixels", job_no), "0",
                            $sformatf("%0d", bad));
        end
        if (covered != screen_px) begin
            report_mismatch($sformatf("job %0d clear coverage", job_no),
                            $sformatf("%0d", screen_px), $sformatf("%0d", covered));
        end
    endtask

    // sampled on the rising edge, inputs move on the falling edge
    always @(posedge vif) begin
        if (!rst_n) begin
            in_job = 1'b0;
            armed = 1'b1;
            done_prev = 1'b0;
            start_was_low = 1'b0;
            job_no = 0;
            job_writes = 0;
        end else begin
            if (vga_plot && vga_ready) begin
                take_write();
            end
            if (done && !done_prev) begin
                if (!in_job) begin
                    report_problem("done rose with no job in progress");
                end else begin
                    finish_job();
                end
                in_job = 1'b0;
            end
            // start seen low last edge, done must be gone by now
            if (done && start_was_low) begin
                report_problem("done still high a cycle after start fell");
            end
            if (start && armed && !in_job && !done) begin
                job_no++;
                job_cx = int'(centre_x);
                job_cy = int'(centre_y);
                job_r = int'(radius);
                job_col = colour;
                job_writes = 0;
                build_expected();
                in_job = 1'b1;
                armed = 1'b0;
            end
            if (!start && !in_job) begin
                armed = 1'b1;
            end
            start_was_low = !start;
            done_prev = done;
        end
    end

endmodule

`default_nettype wire

// ==== sim/circle_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "circle_settings.svh"

module circle_tb;

    localparam int period = 40;
    localparam int job_count = 16;
    localparam int x_w = `X_BITS;
    localparam int y_w = `Y_BITS;
    localparam int r_w = `RADIUS_BITS;
    // twice the clear plus eight pixels for every possible step plus the pauses
    localparam longint job_cycles =
        2 * (`SCREEN_W * `SCREEN_H + 8 * (2 ** `RADIUS_BITS)) + 48;
    localparam longint time_limit = (job_count + 1) * job_cycles * period;

    logic                     vif;
    logic                     rst_n;
    logic                     start;
    logic [`X_BITS-1:0]       centre_x;
    logic [`Y_BITS-1:0]       centre_y;
    logic [`RADIUS_BITS-1:0]  radius;
    logic [`COLOUR_BITS-1:0]  colour;
    logic                     done;
    logic [`X_BITS-1:0]       vga_x;
    logic [`Y_BITS-1:0]       vga_y;
    logic [`COLOUR_BITS-1:0]  vga_colour;
    logic                     vga_plot;
    logic                     vga_ready;

    int checker_errors;
    int jobs_seen;
    int total_writes;
    int tb_errors;
    int jobs_run;

    circle_top i_circle_top (
        .vif        (vif),
        .rst_n      (rst_n),
        .start      (start),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .radius     (radius),
        .colour     (colour),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot),
        .vga_ready  (vga_ready)
    );

    circle_checker i_circle_checker (
        .vif          (vif),
        .rst_n        (rst_n),
        .start        (start),
        .centre_x     (centre_x),
        .centre_y     (centre_y),
        .radius       (radius),
        .colour       (colour),
        .done         (done),
        .vga_x        (vga_x),
        .vga_y        (vga_y),
        .vga_colour   (vga_colour),
        .vga_plot     (vga_plot),
        .vga_ready    (vga_ready),
        .errors       (checker_errors),
        .jobs_seen    (jobs_seen),
        .total_writes (total_writes)
    );

    initial begin
        vif = 1'b0;
        forever #(period / 2) vif = ~vif;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge vif);
    endtask

    // vga adapter back-pressure with ready low about a third of the time
    task automatic drive_ready();
        forever begin
            @(negedge vif);
            vga_ready = ($urandom_range(2, 0) != 0);
        end
    endtask

    // one job through the start/done handshake
    task automatic run_job(input int cx, input int cy, input int r);
        @(negedge vif);
        centre_x = x_w'(cx);
        centre_y = y_w'(cy);
        radius = r_w'(r);
        colour = `COLOUR_BITS'($urandom_range(7, 1));
        start = 1'b1;
        while (!done) begin
            @(negedge vif);
        end
        jobs_run++;
        wait_cycles($urandom_range(20, 0));
        start = 1'b0;
        // at least one edge with start low so the next job is new
        wait_cycles($urandom_range(20, 1));
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        centre_x = '0;
        centre_y = '0;
        radius = '0;
        colour = '0;
        vga_ready = 1'b0;
        tb_errors = 0;
        jobs_run = 0;
        void'($urandom(32'he238fc66));
        fork
            drive_ready();
        join_none
        repeat (16) @(negedge vif);
        rst_n = 1'b1;
        // idle with start low where no writes are allowed
        wait_cycles($urandom_range(40, 10));

        // corners
        run_job(0, 0, $urandom_range(60, 1));
        run_job(`SCREEN_W - 1, 0, $urandom_range(60, 1));
        run_job(0, `SCREEN_H - 1, $urandom_range(60, 1));
        run_job(`SCREEN_W - 1, `SCREEN_H - 1, $urandom_range(60, 1));
        // edges
        run_job(`SCREEN_W / 2, 0, $urandom_range(60, 1));
        run_job(0, `SCREEN_H / 2, $urandom_range(60, 1));
        run_job(`SCREEN_W - 1, `SCREEN_H / 2, $urandom_range(60, 1));
        run_job(`SCREEN_W / 2, `SCREEN_H - 1, $urandom_range(60, 1));
        // inside on a coarse grid
        for (int i = 0; i < 3; i++) begin
            run_job(40 * $urandom_range(3, 1), 30 * $urandom_range(3, 1),
                    $urandom_range(28, 2));
        end
        // extreme radius
        run_job($urandom_range(`SCREEN_W - 1, 0), $urandom_range(`SCREEN_H - 1, 0), 0);
        run_job($urandom_range(`SCREEN_W - 1, 0), $urandom_range(`SCREEN_H - 1, 0), 1);
        run_job($urandom_range(`SCREEN_W - 1, 0), $urandom_range(`SCREEN_H - 1, 0), 255);
        // any job with a centre that may lie off screen
        for (int i = 0; i < 2; i++) begin
            run_job($urandom_range(255, 0), $urandom_range(127, 0), $urandom_range(255, 0));
        end

        wait_cycles(10);
        if (jobs_seen != job_count) begin
            tb_errors++;
            $display("CHECK FAILED job count expected %0d actual %0d", job_count, jobs_seen);
        end
        $display("jobs %0d, writes %0d, checker errors %0d, testbench errors %0d",
                 jobs_seen, total_writes, checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(time_limit);
        $display("watchdog expired with %0d of %0d jobs done", jobs_run, job_count);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
